/* logic/logger_pkg.sv */
package logger_pkg;

	////////////////////////////////////////////////////////////
	// Meter input
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [11:0] voltage;
		logic [11:0] current;
	} meter_sample_t;

	////////////////////////////////////////////////////////////
	// Stored record, 32 bits
	////////////////////////////////////////////////////////////

	// Meter payload is {voltage, current}
	// Logic payload is {pins, 8'h00}
	// Checksum is the low six bits of a byte sum
	//   meter: voltage[11:4] + {voltage[3:0], current[11:8]} + current[7:0]
	//   logic: pins[15:8] + pins[7:0]
	typedef struct packed {
		logic [23:0] payload;   // Bits 31..8
		logic [5:0]  checksum;  // Bits 7..2
		logic        kind;      // 0 meter, 1 logic
		logic        valid;     // Always set in a stored record
	} record_t;

	localparam logic KIND_METER = 1'b0;
	localparam logic KIND_LOGIC = 1'b1;

	function automatic logic [5:0] meter_checksum(input meter_sample_t s);
		logic [9:0] sum;
		sum = {2'b00, s.voltage[11:4]}
			+ {2'b00, s.voltage[3:0], s.current[11:8]}
			+ {2'b00, s.current[7:0]};
		return sum[5:0];
	endfunction

	function automatic logic [5:0] logic_checksum(input logic [15:0] pins);
		logic [8:0] sum;
		sum = {1'b0, pins[15:8]} + {1'b0, pins[7:0]};
		return sum[5:0];
	endfunction

	////////////////////////////////////////////////////////////
	// Wishbone byte master, classic cycle
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [7:0] dat;
	} wb_byte_req_t;

	// First byte of each dumped record
	localparam logic [7:0] METER_HEADER = 8'h0A;
	localparam logic [7:0] LOGIC_HEADER = 8'h0C;

	// Run control of the record store
	typedef enum logic [1:0] {
		RUN_IDLE,
		RUN_SAMPLING,
		RUN_DUMPING,
		RUN_DONE
	} run_state_e;

endpackage

/* logic/meter_framer.sv */
`timescale 1ns/10ps

module meter_framer (
	input  logic                    clk100,
	input  logic                    rst_p,
	input  logger_pkg::meter_sample_t sample,
	input  logic                    sample_valid,
	output logger_pkg::record_t     rec,
	output logic                    pending,
	input  logic                    take
);

	logic load;

	// Samples arriving while a record waits are dropped
	assign load = sample_valid && !pending;

	always_ff @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			pending <= 1'b0;
		end else if (pending) begin
			if (take) begin
				pending <= 1'b0;  // Store accepted it
			end
		end else if (load) begin
			pending <= 1'b1;
		end
	end

	// Record payload
	always_ff @(posedge clk100) begin
		if (load) begin
			rec.payload  <= {sample.voltage, sample.current};
			rec.checksum <= logger_pkg::meter_checksum(sample);
			rec.kind     <= logger_pkg::KIND_METER;
			rec.valid    <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// The store only takes what is on offer
	a_take_needs_pending : assert property (
		@(posedge clk100) disable iff (rst_p)
		take |-> pending
	);

endmodule

/* logic/logic_event_capture.sv */
`timescale 1ns/10ps

module logic_event_capture (
	input  logic                clk100,
	input  logic                rst_p,
	input  logic [15:0]         probe_pins,
	output logger_pkg::record_t rec,
	output logic                pending,
	input  logic                take
);

	logic [15:0] pins_meta;   // First synchronizer stage
	logic [15:0] pins_sync;   // Second stage
	logic [15:0] last_word;   // Last pattern turned into a record
	logic        load;

	// A change is looked at only once the previous event is gone
	assign load = (pins_sync != last_word) && !pending;

	////////////////////////////////////////////////////////////
	// Synchronizer and event detect
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			pins_meta <= '0;
			pins_sync <= '0;
			last_word <= '0;  // First nonzero pattern is an event
			pending   <= 1'b0;
		end else begin
			pins_meta <= probe_pins;
			pins_sync <= pins_meta;
			if (pending) begin
				if (take) begin
					pending <= 1'b0;
				end
			end else if (load) begin
				pending   <= 1'b1;
				last_word <= pins_sync;
			end
		end
	end

	// Event record
	always_ff @(posedge clk100) begin
		if (load) begin
			rec.payload  <= {pins_sync, 8'h00};
			rec.checksum <= logger_pkg::logic_checksum(pins_sync);
			rec.kind     <= logger_pkg::KIND_LOGIC;
			rec.valid    <= 1'b1;
		end
	end

endmodule

/* logic/record_store.sv */
`timescale 1ns/10ps

module record_store #(
	parameter int DEPTH = 64
) (
	input  logic                clk100,
	input  logic                rst_p,
	input  logic                start,
	input  logic                stop,
	input  logger_pkg::record_t meter_rec,
	input  logic                meter_pending,
	output logic                meter_take,
	input  logger_pkg::record_t logic_rec,
	input  logic                logic_pending,
	output logic                logic_take,
	output logger_pkg::record_t rec,
	output logic                rec_valid,
	input  logic                rec_taken,
	output logic                dump_done
);

	localparam int AW = $clog2(DEPTH);

	logger_pkg::run_state_e state;

	logic [AW:0]         wr_cnt;  // Records stored, one extra bit for full
	logic [AW:0]         rd_cnt;  // Records handed to the serializer
	logger_pkg::record_t mem [DEPTH];

	logic                full;
	logic                sampling;
	logic                wr_en;
	logger_pkg::record_t wr_rec;

	assign sampling = (state == logger_pkg::RUN_SAMPLING);
	assign full     = wr_cnt[AW];  // DEPTH is a power of two

	////////////////////////////////////////////////////////////
	// Source arbitration
	////////////////////////////////////////////////////////////

	// Logic events win over meter samples
	assign logic_take = sampling && !full && logic_pending;
	assign meter_take = sampling && !full && meter_pending && !logic_pending;

	assign wr_en  = logic_take || meter_take;
	assign wr_rec = logic_take ? logic_rec : meter_rec;

	////////////////////////////////////////////////////////////
	// Run control and pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			state  <= logger_pkg::RUN_IDLE;
			wr_cnt <= '0;
			rd_cnt <= '0;
		end else begin
			case (state)
				logger_pkg::RUN_IDLE, logger_pkg::RUN_DONE: begin
					if (start) begin
						state  <= logger_pkg::RUN_SAMPLING;
						wr_cnt <= '0;  // New run, empty buffer
						rd_cnt <= '0;
					end
				end
				logger_pkg::RUN_SAMPLING: begin
					if (wr_en) begin
						wr_cnt <= wr_cnt + 1'b1;
					end
					if (stop || full) begin
						state <= logger_pkg::RUN_DUMPING;
					end
				end
				logger_pkg::RUN_DUMPING: begin
					if (rd_cnt == wr_cnt) begin
						state <= logger_pkg::RUN_DONE;  // All records sent
					end else if (rec_taken) begin
						rd_cnt <= rd_cnt + 1'b1;
					end
				end
				default: begin
					state <= logger_pkg::RUN_IDLE;
				end
			endcase
		end
	end

	// Record buffer
	always_ff @(posedge clk100) begin
		if (wr_en) begin
			mem[wr_cnt[AW-1:0]] <= wr_rec;
		end
	end

	// Oldest unsent record, held until the serializer is done with it
	assign rec       = mem[rd_cnt[AW-1:0]];
	assign rec_valid = (state == logger_pkg::RUN_DUMPING) && (rd_cnt != wr_cnt);
	assign dump_done = (state == logger_pkg::RUN_DONE);

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	a_no_write_full : assert property (
		@(posedge clk100) disable iff (rst_p)
		full |=> $stable(wr_cnt) || state == logger_pkg::RUN_SAMPLING && wr_cnt <= 1
	);

	a_rd_behind_wr : assert property (
		@(posedge clk100) disable iff (rst_p)
		rd_cnt <= wr_cnt
	);

endmodule

/* logic/dump_serializer.sv */
`timescale 1ns/10ps

module dump_serializer (
	input  logic                     clk100,
	input  logic                     rst_p,
	input  logger_pkg::record_t      rec,
	input  logic                     rec_valid,
	output logic                     rec_taken,
	output logger_pkg::wb_byte_req_t wb_req,
	input  logic                     wb_ack
);

	typedef enum logic [1:0] {
		SER_IDLE,  // Waiting for a record
		SER_BUS,   // Byte on the bus, waiting for ack
		SER_GAP,   // Strobe low for one cycle between bytes
		SER_TAKE   // Record finished
	} ser_state_e;

	ser_state_e state;
	logic [2:0] byte_cnt;  // 0 header, 1..4 payload, 5 checksum

	// Picks byte idx of the six byte frame
	function automatic logic [7:0] byte_of(input logger_pkg::record_t r, input logic [2:0] idx);
		logic [7:0] b;
		case (idx)
			3'd0: b = r.kind ? logger_pkg::LOGIC_HEADER : logger_pkg::METER_HEADER;
			3'd1: b = r.kind ? r.payload[23:16] : {4'h0, r.payload[23:20]};
			3'd2: b = r.kind ? r.payload[15:8] : r.payload[19:12];
			3'd3: b = r.kind ? 8'h00 : {4'h0, r.payload[11:8]};
			3'd4: b = r.kind ? 8'h00 : r.payload[7:0];
			default: b = {2'b00, r.checksum};
		endcase
		return b;
	endfunction

	////////////////////////////////////////////////////////////
	// Byte sequencer and Wishbone master
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk100 or posedge rst_p) begin
		if (rst_p) begin
			state    <= SER_IDLE;
			byte_cnt <= '0;
			wb_req   <= '0;
		end else begin
			case (state)
				SER_IDLE: begin
					if (rec_valid) begin
						byte_cnt   <= 3'd0;
						wb_req.cyc <= 1'b1;
						wb_req.stb <= 1'b1;
						wb_req.we  <= 1'b1;
						wb_req.dat <= byte_of(rec, 3'd0);
						state      <= SER_BUS;
					end
				end
				SER_BUS: begin
					if (wb_ack) begin
						wb_req.cyc <= 1'b0;
						wb_req.stb <= 1'b0;
						wb_req.we  <= 1'b0;
						if (byte_cnt == 3'd5) begin
							state <= SER_TAKE;
						end else begin
							byte_cnt <= byte_cnt + 3'd1;
							state    <= SER_GAP;
						end
					end
				end
				SER_GAP: begin
					wb_req.cyc <= 1'b1;
					wb_req.stb <= 1'b1;
					wb_req.we  <= 1'b1;
					wb_req.dat <= byte_of(rec, byte_cnt);
					state      <= SER_BUS;
				end
				default: begin
					state <= SER_IDLE;  // Store moves on during this cycle
				end
			endcase
		end
	end

	assign rec_taken = (state == SER_TAKE);

	// Held byte survives any amount of back-pressure
	a_dat_stable : assert property (
		@(posedge clk100) disable iff (rst_p)
		wb_req.stb && !wb_ack |=> wb_req.stb && $stable(wb_req.dat)
	);

endmodule

/* logic/data_logger.sv */
`timescale 1ns/10ps

module data_logger #(
	parameter int DEPTH = 64
) (
	input  logic                      clk100,
	input  logic                      rst_p,
	input  logic                      start,
	input  logic                      stop,
	input  logger_pkg::meter_sample_t sample,
	input  logic                      sample_valid,
	input  logic [15:0]               probe_pins,
	output logger_pkg::wb_byte_req_t  wb_req,
	input  logic                      wb_ack,
	output logic                      dump_done
);

	logger_pkg::record_t meter_rec;
	logic                meter_pending;
	logic                meter_take;

	logger_pkg::record_t logic_rec;
	logic                logic_pending;
	logic                logic_take;

	logger_pkg::record_t dump_rec;    // Store to serializer
	logic                rec_valid;
	logic                rec_taken;

	////////////////////////////////////////////////////////////
	// Sources
	////////////////////////////////////////////////////////////

	meter_framer i_meter_framer (
		.clk100       (clk100),
		.rst_p        (rst_p),
		.sample       (sample),
		.sample_valid (sample_valid),
		.rec          (meter_rec),
		.pending      (meter_pending),
		.take         (meter_take)
	);

	logic_event_capture i_logic_event_capture (
		.clk100     (clk100),
		.rst_p      (rst_p),
		.probe_pins (probe_pins),
		.rec        (logic_rec),
		.pending    (logic_pending),
		.take       (logic_take)
	);

	////////////////////////////////////////////////////////////
	// Buffer and readout
	////////////////////////////////////////////////////////////

	record_store #(
		.DEPTH (DEPTH)
	) i_record_store (
		.clk100        (clk100),
		.rst_p         (rst_p),
		.start         (start),
		.stop          (stop),
		.meter_rec     (meter_rec),
		.meter_pending (meter_pending),
		.meter_take    (meter_take),
		.logic_rec     (logic_rec),
		.logic_pending (logic_pending),
		.logic_take    (logic_take),
		.rec           (dump_rec),
		.rec_valid     (rec_valid),
		.rec_taken     (rec_taken),
		.dump_done     (dump_done)
	);

	dump_serializer i_dump_serializer (
		.clk100    (clk100),
		.rst_p     (rst_p),
		.rec       (dump_rec),
		.rec_valid (rec_valid),
		.rec_taken (rec_taken),
		.wb_req    (wb_req),
		.wb_ack    (wb_ack)
	);

endmodule

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Bytes still owed by the DUT, oldest first
logic [7:0] exp_bytes[$];

// Full period 32-bit LCG
function automatic logic [31:0] lcg_step(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

////////////////////////////////////////////////////////////
// Reference model of the dump format
////////////////////////////////////////////////////////////

// Six bytes of one logged input, first byte in bits 47..40
function automatic logic [47:0] expected_bytes(input logic is_logic, input logic [11:0] v,
		input logic [11:0] c, input logic [15:0] pins);
	logic [7:0] sum;
	if (is_logic) begin
		sum = pins[15:8] + pins[7:0];  // Only six bits survive
		return {logger_pkg::LOGIC_HEADER, pins[15:8], pins[7:0], 16'h0000, 2'b00, sum[5:0]};
	end
	// Meter frame carries the 12-bit values split into nibble and byte
	sum = v[11:4] + {v[3:0], c[11:8]} + c[7:0];
	return {logger_pkg::METER_HEADER, 4'h0, v[11:8], v[7:0], 4'h0, c[11:8], c[7:0],
		2'b00, sum[5:0]};
endfunction

// Queue one frame, header first
task automatic push_frame(input logic [47:0] frame);
	for (int i = 5; i >= 0; i--) begin
		exp_bytes.push_back(frame[i*8 +: 8]);
	end
endtask

`endif

/* testbench/tb_data_logger.sv */
`timescale 1ns/10ps

module tb_data_logger;

	localparam int DEPTH       = 16;
	localparam int CYCLE_LIMIT = 4000;  // Five tests, longest dump near 800 cycles
	localparam int GAP         = 10;    // Idle cycles after each input

	logic                      clk100 = 1'b0;
	logic                      rst_p;
	logic                      start;
	logic                      stop;
	logger_pkg::meter_sample_t sample;
	logic                      sample_valid;
	logic [15:0]               probe_pins;
	logger_pkg::wb_byte_req_t  wb_req;
	logic                      wb_ack = 1'b0;
	logic                      dump_done;

	string       test_name = "idle_after_reset";
	int          error_count;
	int          errors_before;
	int          tests_failed;
	int          test_bytes;
	int          total_bytes;
	int          hold_errors;
	int          cycle_count;
	int          ack_wait;
	bit          ack_armed;
	logic [31:0] stim_seed = 32'h570fe83c;
	logic [31:0] ack_seed  = 32'h570fe83c;
	logic [15:0] pins_now  = '0;
	logic [7:0]  exp_byte;
	logic        held_stb  = 1'b0;  // Strobe seen without ack last edge
	logic [7:0]  held_dat;
	logic        acked_last = 1'b0;  // Transfer acknowledged last edge

	`include "tb_model.svh"

	data_logger #(
		.DEPTH (DEPTH)
	) i_dut (
		.clk100       (clk100),
		.rst_p        (rst_p),
		.start        (start),
		.stop         (stop),
		.sample       (sample),
		.sample_valid (sample_valid),
		.probe_pins   (probe_pins),
		.wb_req       (wb_req),
		.wb_ack       (wb_ack),
		.dump_done    (dump_done)
	);

	always #10 clk100 = ~clk100;

	always @(posedge clk100) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles, a dump never finished", cycle_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Wishbone slave, random ack delay
	////////////////////////////////////////////////////////////

	always @(posedge clk100) begin
		if (wb_ack) begin
			wb_ack <= 1'b0;  // One ack per strobe
		end else if (wb_req.cyc && wb_req.stb) begin
			if (!ack_armed) begin
				ack_seed  = lcg_step(ack_seed);
				ack_wait  = int'(ack_seed[31:16] % 16'd6);  // 0 to 5 cycles
				ack_armed = 1'b1;
			end
			if (ack_wait == 0) begin
				wb_ack    <= 1'b1;
				ack_armed = 1'b0;
			end else begin
				ack_wait = ack_wait - 1;
			end
		end
	end

	// Bus rules and byte comparison
	always @(posedge clk100) begin
		if (!rst_p) begin
			if (wb_req.cyc || wb_req.stb) begin
				assert (wb_req.cyc && wb_req.stb && wb_req.we) else begin
					$display("%s: cyc, stb and we were not raised together", test_name);
					hold_errors++;
					error_count++;
				end
			end
			if (held_stb) begin
				assert (wb_req.stb && wb_req.dat == held_dat) else begin
					$display("ERROR %s: expected held byte %02h, actual %02h (stb %b)",
						test_name, held_dat, wb_req.dat, wb_req.stb);
					hold_errors++;
					error_count++;
				end
			end
			// Strobe drops for a cycle after each ack
			if (acked_last) begin
				assert (!wb_req.cyc && !wb_req.stb) else begin
					$display("%s: cyc or stb stayed high after an ack", test_name);
					hold_errors++;
					error_count++;
				end
			end
			if (wb_req.stb && wb_ack) begin
				test_bytes++;
				total_bytes++;
				assert (exp_bytes.size() > 0) else begin
					$display("%s: byte %02h was sent but none was expected",
						test_name, wb_req.dat);
					error_count++;
				end
				if (exp_bytes.size() > 0) begin
					exp_byte = exp_bytes.pop_front();
					assert (wb_req.dat == exp_byte) else begin
						$display("ERROR %s: expected %02h, actual %02h",
							test_name, exp_byte, wb_req.dat);
						error_count++;
					end
				end
			end
			held_stb   = wb_req.stb && !wb_ack;
			held_dat   = wb_req.dat;
			acked_last = wb_req.stb && wb_ack;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	task automatic pulse_control(input bit is_stop);
		@(posedge clk100);
		if (is_stop) begin
			stop <= 1'b1;
		end else begin
			start <= 1'b1;
		end
		@(posedge clk100);
		start <= 1'b0;
		stop  <= 1'b0;
	endtask

	task automatic send_sample(input bit expect_it);
		logic [11:0] v;
		logic [11:0] c;
		stim_seed = lcg_step(stim_seed);
		v = stim_seed[31:20];
		stim_seed = lcg_step(stim_seed);
		c = stim_seed[31:20];
		@(posedge clk100);
		sample       <= '{voltage: v, current: c};
		sample_valid <= 1'b1;
		@(posedge clk100);
		sample_valid <= 1'b0;
		if (expect_it) begin
			push_frame(expected_bytes(1'b0, v, c, 16'h0000));
		end
		repeat (GAP) @(posedge clk100);
	endtask

	task automatic change_pins();
		logic [15:0] p;
		stim_seed = lcg_step(stim_seed);
		p = stim_seed[31:16];
		if (p == pins_now) begin
			p = ~p;  // Has to be a real change
		end
		pins_now = p;
		@(posedge clk100);
		probe_pins <= p;
		push_frame(expected_bytes(1'b1, 12'h000, 12'h000, p));
		repeat (GAP) @(posedge clk100);
	endtask

	task automatic wait_dump();
		@(posedge clk100);
		while (!dump_done) begin
			@(posedge clk100);
		end
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		test_bytes    = 0;
		errors_before = error_count;
	endtask

	task automatic finish_test(input int want_bytes);
		assert (test_bytes == want_bytes) else begin
			$display("ERROR %s: expected %0d bytes, actual %0d",
				test_name, want_bytes, test_bytes);
			error_count++;
		end
		assert (exp_bytes.size() == 0) else begin
			$display("%s: %0d expected bytes were never sent", test_name, exp_bytes.size());
			error_count++;
		end
		exp_bytes.delete();
		if (error_count != errors_before) begin
			tests_failed++;
		end
		$display("test %s %s, %0d bytes", test_name,
			(error_count == errors_before) ? "passed" : "failed", test_bytes);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int n;
		rst_p        = 1'b1;
		start        = 1'b0;
		stop         = 1'b0;
		sample       = '0;
		sample_valid = 1'b0;
		probe_pins   = '0;
		repeat (16) @(posedge clk100);
		rst_p <= 1'b0;

		begin_test("idle_after_reset");
		repeat (50) begin
			@(posedge clk100);
			assert (!wb_req.cyc && !wb_req.stb && !dump_done) else begin
				$display("ERROR %s: expected cyc stb done 000, actual %b%b%b",
					test_name, wb_req.cyc, wb_req.stb, dump_done);
				error_count++;
			end
		end
		finish_test(0);

		// Start then stop with nothing logged
		begin_test("empty_run");
		pulse_control(1'b0);
		pulse_control(1'b1);
		wait_dump();
		finish_test(0);

		begin_test("five_meter_samples");
		pulse_control(1'b0);
		repeat (4) @(posedge clk100);
		repeat (5) send_sample(1'b1);
		pulse_control(1'b1);
		wait_dump();
		finish_test(30);

		begin_test("interleaved_sources");
		pulse_control(1'b0);
		repeat (4) @(posedge clk100);
		repeat (4) begin
			send_sample(1'b1);
			change_pins();
		end
		pulse_control(1'b1);
		wait_dump();
		finish_test(48);

		// No stop, the full buffer ends the run
		begin_test("buffer_full");
		pulse_control(1'b0);
		repeat (4) @(posedge clk100);
		for (n = 0; n < 20; n++) begin
			send_sample(n < DEPTH);
		end
		wait_dump();
		finish_test(6 * DEPTH);

		if (hold_errors != 0) begin
			tests_failed++;
		end
		$display("test random_ack_hold %s, %0d bytes",
			(hold_errors == 0) ? "passed" : "failed", total_bytes);

		$display("6 tests, %0d failed, %0d errors, %0d bytes checked",
			tests_failed, error_count, total_bytes);
		if (error_count == 0 && tests_failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+testbench
logic/logger_pkg.sv
logic/meter_framer.sv
logic/logic_event_capture.sv
logic/record_store.sv
logic/dump_serializer.sv
logic/data_logger.sv
testbench/tb_data_logger.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the data logger testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_data_logger \
	-f tb.f -o tb_data_logger_sim || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_data_logger_sim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "Simulator exited with an error" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0
